// File: src/byte_cpu_macros.svh
`ifndef BYTE_CPU_MACROS_SVH
`define BYTE_CPU_MACROS_SVH

// Data path and register width
`define BYTE_CPU_DATA_W 8

// Program counter width, one instruction word per address
`define BYTE_CPU_PC_W 8

// Instruction word width
`define BYTE_CPU_INSTR_W 16

// Index into the four general registers
`define BYTE_CPU_REG_ADDR_W 2

// Data RAM words, reached by the 8-bit direct address
`define BYTE_CPU_RAM_DEPTH 256

`endif

// File: src/byte_cpu_pkg.sv
`default_nettype none

`include "byte_cpu_macros.svh"

package byte_cpu_pkg;

    // Instruction word layout
    //   [15:12] opcode, [11:10] rd, [9:8] ra
    //   [7:0] immediate, RAM address or jump target
    //   ALU form keeps the operation in [6:4] and rb in [1:0]
    typedef enum logic [3:0] {
        OP_LDI  = 4'h0, // rd <= imm
        OP_ALU  = 4'h1, // rd <= ra op rb, flags updated
        OP_LD   = 4'h2, // rd <= ram[addr]
        OP_ST   = 4'h3, // ram[addr] <= ra
        OP_JMP  = 4'h4, // Always taken
        OP_JZ   = 4'h5, // Taken on zero flag
        OP_JC   = 4'h6, // Taken on carry flag
        OP_OUT  = 4'h7, // ra onto the tx stream
        OP_IN   = 4'h8, // rd <= next rx byte
        OP_HALT = 4'h9,
        OP_NOP  = 4'ha
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1, // Carry holds the borrow
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_PASS = 3'd5  // Result is operand b
    } alu_op_e;

    // Registered after each ALU instruction only
    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } flags_t;

    typedef struct packed {
        logic [`BYTE_CPU_INSTR_W-1:0] instr;
        logic [`BYTE_CPU_PC_W-1:0]    pc;
    } fetch_item_t;

    typedef struct packed {
        opcode_e                         opcode;
        alu_op_e                         alu_op;
        logic [`BYTE_CPU_REG_ADDR_W-1:0] rd;   // Write-back target
        logic [`BYTE_CPU_DATA_W-1:0]     op_a; // Value of ra
        logic [`BYTE_CPU_DATA_W-1:0]     op_b; // rb for ALU, else the immediate
        logic [`BYTE_CPU_DATA_W-1:0]     imm;  // Address or jump target
        logic [`BYTE_CPU_PC_W-1:0]       pc;
    } exec_item_t;

endpackage : byte_cpu_pkg

`default_nettype wire

// File: src/stage_link.sv
`timescale 1ns/1ps
`default_nettype none

// One pipeline item between two stages
// Item moves on valid && ready, payload held while stalled
interface stage_link #(
    parameter type payload_t = logic
);
    logic     valid;   // Upstream holds an item
    logic     ready;   // Downstream takes it this cycle
    payload_t payload;
    logic     flush;   // Jump taken, passed upstream by each receiver

    modport source (
        output valid,
        output payload,
        input  ready,
        input  flush
    );

    // Receiver also drives flush toward the older side of the pipe
    modport sink (
        input  valid,
        input  payload,
        output ready,
        output flush
    );

endinterface : stage_link

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "byte_cpu_macros.svh"

module register_file (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  wr_en,
    input  wire  [`BYTE_CPU_REG_ADDR_W-1:0]      wr_addr,
    input  wire  [`BYTE_CPU_DATA_W-1:0]          wr_data,
    input  wire  [`BYTE_CPU_REG_ADDR_W-1:0]      rd_addr_a,
    input  wire  [`BYTE_CPU_REG_ADDR_W-1:0]      rd_addr_b,
    output logic [`BYTE_CPU_DATA_W-1:0]          rd_data_a,
    output logic [`BYTE_CPU_DATA_W-1:0]          rd_data_b
);

    logic [`BYTE_CPU_DATA_W-1:0] regs [2**`BYTE_CPU_REG_ADDR_W]; // r0..r3

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through, so decode sees the value execute writes this cycle
    always_comb begin
        if (wr_en && (wr_addr == rd_addr_a)) begin
            rd_data_a = wr_data;
        end else begin
            rd_data_a = regs[rd_addr_a];
        end
    end

    always_comb begin
        if (wr_en && (wr_addr == rd_addr_b)) begin
            rd_data_b = wr_data;
        end else begin
            rd_data_b = regs[rd_addr_b];
        end
    end

endmodule : register_file

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "byte_cpu_macros.svh"

module alu (
    input  wire byte_cpu_pkg::alu_op_e          op,
    input  wire [`BYTE_CPU_DATA_W-1:0]          a,
    input  wire [`BYTE_CPU_DATA_W-1:0]          b,
    output logic [`BYTE_CPU_DATA_W-1:0]         result,
    output byte_cpu_pkg::flags_t                flags_out
);

    logic [`BYTE_CPU_DATA_W:0] wide; // Extra top bit is carry or borrow

    always_comb begin
        case (op)
            byte_cpu_pkg::ALU_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
            end
            byte_cpu_pkg::ALU_SUB: begin
                wide = {1'b0, a} - {1'b0, b}; // Top bit set when b > a
            end
            byte_cpu_pkg::ALU_AND: begin
                wide = {1'b0, a & b};
            end
            byte_cpu_pkg::ALU_OR: begin
                wide = {1'b0, a | b};
            end
            byte_cpu_pkg::ALU_XOR: begin
                wide = {1'b0, a ^ b};
            end
            byte_cpu_pkg::ALU_PASS: begin
                wide = {1'b0, b};
            end
            default: begin
                wide = '0; // Unused encodings give zero
            end
        endcase
    end

    assign result = wide[`BYTE_CPU_DATA_W-1:0];

    // Logic ops never set the top bit, so carry is 0 for them
    assign flags_out.carry    = wide[`BYTE_CPU_DATA_W];
    assign flags_out.zero     = (result == '0);
    assign flags_out.negative = result[`BYTE_CPU_DATA_W-1]; // Sign bit

endmodule : alu

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "byte_cpu_macros.svh"

module fetch_stage (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           run,
    input  wire                           prog_we,
    input  wire [`BYTE_CPU_PC_W-1:0]      prog_addr,
    input  wire [`BYTE_CPU_INSTR_W-1:0]   prog_data,
    input  wire [`BYTE_CPU_PC_W-1:0]      redirect_pc, // Jump target from execute
    stage_link.source                     f2d
);

    logic [`BYTE_CPU_INSTR_W-1:0] imem [2**`BYTE_CPU_PC_W];
    logic [`BYTE_CPU_PC_W-1:0]    pc;
    logic                         slot_open;
    logic                         issue;

    assign slot_open = !f2d.valid || f2d.ready; // Empty or emptied this edge
    assign issue     = run && slot_open && !f2d.flush;

    // Words never loaded read back as NOP
    initial begin
        for (int i = 0; i < 2**`BYTE_CPU_PC_W; i++) begin
            imem[i] = {byte_cpu_pkg::OP_NOP, {(`BYTE_CPU_INSTR_W-4){1'b0}}};
        end
    end

    always @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data; // Load port, used while run is low
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= '0;
            f2d.valid <= 1'b0;
        end else if (f2d.flush) begin
            pc        <= redirect_pc; // Younger item in the slot is dropped
            f2d.valid <= 1'b0;
        end else if (issue) begin
            pc        <= pc + 1'b1;
            f2d.valid <= 1'b1;
        end else if (f2d.ready) begin
            f2d.valid <= 1'b0;
        end
    end

    // Synchronous memory read lands straight in the outgoing slot
    always_ff @(posedge clk) begin
        if (issue) begin
            f2d.payload.instr <= imem[pc];
            f2d.payload.pc    <= pc;
        end
    end

    a_f2d_payload_known : assert property (@(posedge clk) disable iff (reset)
        f2d.valid |-> !$isunknown(f2d.payload));

endmodule : fetch_stage

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "byte_cpu_macros.svh"

module decode_stage (
    input  wire                                  clk,
    input  wire                                  reset,
    stage_link.sink                              f2d,
    stage_link.source                            d2e,
    output logic [`BYTE_CPU_REG_ADDR_W-1:0]      rd_addr_a,
    output logic [`BYTE_CPU_REG_ADDR_W-1:0]      rd_addr_b,
    input  wire  [`BYTE_CPU_DATA_W-1:0]          rd_data_a,
    input  wire  [`BYTE_CPU_DATA_W-1:0]          rd_data_b
);

    logic [`BYTE_CPU_INSTR_W-1:0] instr;
    byte_cpu_pkg::exec_item_t     item;
    logic                         take;

    assign instr = f2d.payload.instr;

    assign f2d.flush = d2e.flush; // Fetch drops its slot on the same jump
    // Accept only when the slot frees up and no jump is clearing the pipe
    assign f2d.ready = (!d2e.valid || d2e.ready) && !d2e.flush;
    assign take      = f2d.valid && f2d.ready;

    // Operands are read in the cycle the item is taken, bypass covers the
    // write of the instruction leaving execute on that same edge
    assign rd_addr_a = instr[9:8];
    assign rd_addr_b = instr[1:0];

    always_comb begin
        item.opcode = byte_cpu_pkg::opcode_e'(instr[15:12]);
        item.alu_op = byte_cpu_pkg::alu_op_e'(instr[6:4]); // Only meaningful for ALU
        item.rd     = instr[11:10];
        item.op_a   = rd_data_a;
        item.imm    = instr[7:0];
        item.pc     = f2d.payload.pc;
        if (item.opcode == byte_cpu_pkg::OP_ALU) begin
            item.op_b = rd_data_b;
        end else begin
            item.op_b = instr[7:0]; // Immediate, LDI passes it through the ALU
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            d2e.valid <= 1'b0;
        end else if (d2e.flush) begin
            d2e.valid <= 1'b0; // Held item is younger than the jump
        end else if (take) begin
            d2e.valid <= 1'b1;
        end else if (d2e.ready) begin
            d2e.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            d2e.payload <= item;
        end
    end

    a_d2e_hold : assert property (@(posedge clk) disable iff (reset)
        d2e.valid && !d2e.ready |=> d2e.valid && $stable(d2e.payload));

endmodule : decode_stage

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "byte_cpu_macros.svh"

module execute_stage (
    input  wire                                  clk,
    input  wire                                  reset,
    stage_link.sink                              d2e,
    output logic [`BYTE_CPU_PC_W-1:0]            redirect_pc,
    output logic                                 wr_en,
    output logic [`BYTE_CPU_REG_ADDR_W-1:0]      wr_addr,
    output logic [`BYTE_CPU_DATA_W-1:0]          wr_data,
    input  wire                                  rx_valid,
    input  wire  [`BYTE_CPU_DATA_W-1:0]          rx_data,
    output logic                                 rx_ready,
    output logic                                 tx_valid,
    output logic [`BYTE_CPU_DATA_W-1:0]          tx_data,
    input  wire                                  tx_ready,
    output logic                                 halted
);

    byte_cpu_pkg::exec_item_t    item;
    byte_cpu_pkg::flags_t        flags;     // Registered czn
    byte_cpu_pkg::flags_t        alu_flags;
    byte_cpu_pkg::alu_op_e       alu_sel;
    logic [`BYTE_CPU_DATA_W-1:0] ram [`BYTE_CPU_RAM_DEPTH];
    logic [`BYTE_CPU_DATA_W-1:0] alu_result;
    logic [`BYTE_CPU_DATA_W-1:0] ram_rdata;
    logic                        stall;
    logic                        taken;
    logic                        done;
    logic                        is_alu;

    assign item   = d2e.payload;
    assign is_alu = (item.opcode == byte_cpu_pkg::OP_ALU);

    always_comb begin
        stall = 1'b0;
        taken = 1'b0;
        case (item.opcode)
            byte_cpu_pkg::OP_IN:   stall = !rx_valid;             // Wait for a byte
            byte_cpu_pkg::OP_OUT:  stall = tx_valid && !tx_ready; // Holding reg busy
            byte_cpu_pkg::OP_HALT: stall = tx_valid;              // Drain last byte first
            byte_cpu_pkg::OP_JMP:  taken = 1'b1;
            byte_cpu_pkg::OP_JZ:   taken = flags.zero;
            byte_cpu_pkg::OP_JC:   taken = flags.carry;
            default: ;
        endcase
    end

    assign done        = d2e.valid && !stall;
    // HALT keeps its slot, so nothing younger reaches execute afterward
    assign d2e.ready   = !(d2e.valid && (stall || (item.opcode == byte_cpu_pkg::OP_HALT)));
    assign d2e.flush   = done && taken;
    assign redirect_pc = item.imm;
    assign rx_ready    = d2e.valid && (item.opcode == byte_cpu_pkg::OP_IN);

    // LDI goes through as PASS of the immediate
    assign alu_sel = is_alu ? item.alu_op : byte_cpu_pkg::ALU_PASS;

    alu i_alu (
        .op        (alu_sel),
        .a         (item.op_a),
        .b         (item.op_b),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    assign ram_rdata = ram[item.imm]; // Direct address, read without a clock

    // Write-back only on completion
    always_comb begin
        wr_addr = item.rd;
        case (item.opcode)
            byte_cpu_pkg::OP_LDI, byte_cpu_pkg::OP_ALU: begin
                wr_en   = done;
                wr_data = alu_result;
            end
            byte_cpu_pkg::OP_LD: begin
                wr_en   = done;
                wr_data = ram_rdata;
            end
            byte_cpu_pkg::OP_IN: begin
                wr_en   = done;
                wr_data = rx_data;
            end
            default: begin
                wr_en   = 1'b0;
                wr_data = alu_result;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags    <= '0;
            tx_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            if (done && is_alu) begin
                flags <= alu_flags;
            end
            if (done && (item.opcode == byte_cpu_pkg::OP_OUT)) begin
                tx_valid <= 1'b1;
            end else if (tx_ready) begin
                tx_valid <= 1'b0;
            end
            if (done && (item.opcode == byte_cpu_pkg::OP_HALT)) begin
                halted <= 1'b1; // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done && (item.opcode == byte_cpu_pkg::OP_OUT)) begin
            tx_data <= item.op_a;
        end
        if (done && (item.opcode == byte_cpu_pkg::OP_ST)) begin
            ram[item.imm] <= item.op_a;
        end
    end

    a_no_write_halted : assert property (@(posedge clk) disable iff (reset)
        halted |-> !wr_en);

    a_tx_hold : assert property (@(posedge clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule : execute_stage

`default_nettype wire

// File: src/byte_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "byte_cpu_macros.svh"

module byte_cpu (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             run,       // Fetch issues only while high
    input  wire                             prog_we,
    input  wire  [`BYTE_CPU_PC_W-1:0]       prog_addr,
    input  wire  [`BYTE_CPU_INSTR_W-1:0]    prog_data,
    input  wire                             rx_valid,
    input  wire  [`BYTE_CPU_DATA_W-1:0]     rx_data,
    input  wire                             tx_ready,
    output logic                            rx_ready,
    output logic                            tx_valid,
    output logic [`BYTE_CPU_DATA_W-1:0]     tx_data,
    output logic                            halted
);

    logic [`BYTE_CPU_REG_ADDR_W-1:0] rd_addr_a;
    logic [`BYTE_CPU_REG_ADDR_W-1:0] rd_addr_b;
    logic [`BYTE_CPU_DATA_W-1:0]     rd_data_a;
    logic [`BYTE_CPU_DATA_W-1:0]     rd_data_b;
    logic                            wr_en;
    logic [`BYTE_CPU_REG_ADDR_W-1:0] wr_addr;
    logic [`BYTE_CPU_DATA_W-1:0]     wr_data;
    logic [`BYTE_CPU_PC_W-1:0]       redirect_pc;

    stage_link #(.payload_t(byte_cpu_pkg::fetch_item_t)) f2d_link ();
    stage_link #(.payload_t(byte_cpu_pkg::exec_item_t))  d2e_link ();

    fetch_stage i_fetch (
        .clk, .reset, .run,
        .prog_we, .prog_addr, .prog_data,
        .redirect_pc,
        .f2d (f2d_link.source)
    );

    decode_stage i_decode (
        .clk, .reset,
        .f2d (f2d_link.sink),
        .d2e (d2e_link.source),
        .rd_addr_a, .rd_addr_b,
        .rd_data_a, .rd_data_b
    );

    execute_stage i_execute (
        .clk, .reset,
        .d2e (d2e_link.sink),
        .redirect_pc,
        .wr_en, .wr_addr, .wr_data,
        .rx_valid, .rx_data, .rx_ready,
        .tx_valid, .tx_data, .tx_ready,
        .halted
    );

    register_file i_register_file (
        .clk, .reset,
        .wr_en, .wr_addr, .wr_data,     // From execute
        .rd_addr_a, .rd_addr_b,         // From decode
        .rd_data_a, .rd_data_b
    );

endmodule : byte_cpu

`default_nettype wire

// File: verification/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and a synchronous reset pulse
module clock_gen #(
    parameter real PERIOD_NS    = 40.0,
    parameter int  RESET_CYCLES = 4     // Rising edges that see reset high
) (
    input  wire  restart, // Sampled on the rising edge, starts a fresh reset
    output logic clk,
    output logic reset
);

    int cycles_left = RESET_CYCLES;

    initial clk = 1'b0;
    always #(PERIOD_NS / 2.0) clk = ~clk;

    initial reset <= 1'b1; // Power-on reset

    always @(posedge clk) begin
        if (restart) begin
            reset       <= 1'b1;
            cycles_left <= RESET_CYCLES;
        end else if (cycles_left > 1) begin
            cycles_left <= cycles_left - 1;
        end else begin
            reset       <= 1'b0; // Last reset edge done
            cycles_left <= 0;
        end
    end

endmodule : clock_gen

`default_nettype wire

// File: verification/byte_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "byte_cpu_macros.svh"

module byte_cpu_tb;

    localparam string       STIM_FILE       = "verification/byte_cpu_stimulus.txt";
    localparam int unsigned RAND_SEED       = 32'h37271601;
    localparam int          CYCLES_PER_WORD = 200;
    localparam int          CYCLES_PER_BYTE = 100;
    localparam int          QUIET_CYCLES    = 12;   // Halted cycles watched per block

    logic                         clk;
    logic                         reset;
    logic                         restart;
    logic                         run;
    logic                         prog_we;
    logic [`BYTE_CPU_PC_W-1:0]    prog_addr;
    logic [`BYTE_CPU_INSTR_W-1:0] prog_data;
    logic                         rx_valid;
    logic [`BYTE_CPU_DATA_W-1:0]  rx_data;
    logic                         rx_ready;
    logic                         tx_valid;
    logic [`BYTE_CPU_DATA_W-1:0]  tx_data;
    logic                         tx_ready;
    logic                         halted;

    // Contents of the block being read
    logic [`BYTE_CPU_PC_W-1:0]    prog_addr_q[$];
    logic [`BYTE_CPU_INSTR_W-1:0] prog_word_q[$];
    logic [`BYTE_CPU_DATA_W-1:0]  rx_q[$];
    logic [`BYTE_CPU_DATA_W-1:0]  exp_q[$];

    int cycle_count = 0;
    int cycle_limit = 0;  // Zero until the stimulus file is scanned
    int block_count = 0;

    clock_gen #(.PERIOD_NS(40.0), .RESET_CYCLES(4)) i_clock_gen (
        .restart,
        .clk,
        .reset
    );

    byte_cpu i_byte_cpu (
        .clk, .reset, .run,
        .prog_we, .prog_addr, .prog_data,
        .rx_valid, .rx_data, .rx_ready,
        .tx_valid, .tx_data, .tx_ready,
        .halted
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at the first error");
    endtask

    // Budget from the file, per program word and per stream byte
    task automatic count_cycle_limit(output int limit);
        int    fd;
        string line;
        limit = 0;
        fd    = $fopen(STIM_FILE, "r");
        assert (fd != 0) else stop_on_error({"Cannot open ", STIM_FILE});
        while ($fgets(line, fd) != 0) begin
            case (line[0])
                "P":      limit += CYCLES_PER_WORD;
                "R", "E": limit += CYCLES_PER_BYTE;
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0) begin
            assert (cycle_count < cycle_limit) else
                stop_on_error($sformatf("Timeout, run still going after %0d cycles",
                                        cycle_count));
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        run     <= 1'b0;
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        do @(negedge clk); while (reset); // Sampled mid-cycle
        assert (!tx_valid && !rx_ready && !halted) else
            stop_on_error($sformatf(
                "Mismatch: after reset tx_valid=0x%h rx_ready=0x%h halted=0x%h, expected 0x0",
                tx_valid, rx_ready, halted));
    endtask

    task automatic load_program();
        foreach (prog_addr_q[i]) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= prog_addr_q[i];
            prog_data <= prog_word_q[i];
        end
        @(posedge clk);
        prog_we <= 1'b0; // Last word written on this edge
    endtask

    // Run until halted and tx stays quiet, comparing every accepted byte
    task automatic run_block();
        int   rx_idx;
        int   exp_idx;
        int   quiet;
        logic rx_taken;
        logic tx_taken;
        rx_idx  = 0;
        exp_idx = 0;
        quiet   = 0;
        apply_reset();
        load_program();
        run <= 1'b1;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);                  // Values that the next edge will see
            tx_taken = tx_valid && tx_ready;
            rx_taken = rx_valid && rx_ready;
            if (tx_taken) begin
                assert (exp_idx < exp_q.size()) else
                    stop_on_error($sformatf("Extra tx byte 0x%02h in block %0d",
                                            tx_data, block_count));
                assert (tx_data == exp_q[exp_idx]) else
                    stop_on_error($sformatf(
                        "Mismatch: tx_data got 0x%02h expected 0x%02h (block %0d, byte %0d)",
                        tx_data, exp_q[exp_idx], block_count, exp_idx));
                exp_idx++;
            end
            if (rx_taken) begin
                rx_idx++;
            end
            if (halted) begin
                assert (exp_idx == exp_q.size()) else
                    stop_on_error($sformatf("Core halted after %0d of %0d bytes in block %0d",
                                            exp_idx, exp_q.size(), block_count));
                assert (!tx_valid) else
                    stop_on_error("Mismatch: tx_valid got 0x1 expected 0x0 while halted");
                quiet++;
            end
            @(posedge clk);
            if (!rx_valid || rx_taken) begin // An offered byte holds until taken
                rx_valid <= (rx_idx < rx_q.size()) && ($urandom_range(3) != 0);
                if (rx_idx < rx_q.size()) begin
                    rx_data <= rx_q[rx_idx];
                end
            end
            tx_ready <= ($urandom_range(3) != 0); // Low about one cycle in four
        end
        assert (rx_idx == rx_q.size()) else
            stop_on_error($sformatf("Only %0d of %0d rx bytes taken in block %0d",
                                    rx_idx, rx_q.size(), block_count));
        run      <= 1'b0;
        rx_valid <= 1'b0;
        tx_ready <= 1'b0;
    endtask

    initial begin
        int                           fd;
        int                           fields;
        string                        line;
        logic [`BYTE_CPU_PC_W-1:0]    addr_val;
        logic [`BYTE_CPU_INSTR_W-1:0] word_val;
        logic [`BYTE_CPU_DATA_W-1:0]  byte_val;
        void'($urandom(RAND_SEED));
        restart   <= 1'b0;
        run       <= 1'b0;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        rx_valid  <= 1'b0;
        rx_data   <= '0;
        tx_ready  <= 1'b0;
        count_cycle_limit(cycle_limit);
        fd = $fopen(STIM_FILE, "r");
        assert (fd != 0) else stop_on_error({"Cannot open ", STIM_FILE});
        while ($fgets(line, fd) != 0) begin
            case (line[0])
                "P": begin
                    fields = $sscanf(line, "P %h %h", addr_val, word_val);
                    assert (fields == 2) else stop_on_error({"Bad program line ", line});
                    prog_addr_q.push_back(addr_val);
                    prog_word_q.push_back(word_val);
                end
                "R": begin
                    fields = $sscanf(line, "R %h", byte_val);
                    assert (fields == 1) else stop_on_error({"Bad input line ", line});
                    rx_q.push_back(byte_val);
                end
                "E": begin
                    fields = $sscanf(line, "E %h", byte_val);
                    assert (fields == 1) else stop_on_error({"Bad expected line ", line});
                    exp_q.push_back(byte_val);
                end
                "T": begin
                    run_block();
                    prog_addr_q.delete();
                    prog_word_q.delete();
                    rx_q.delete();
                    exp_q.delete();
                    block_count++;
                end
                default: ; // Comments and blank lines
            endcase
        end
        $fclose(fd);
        assert (block_count > 0) else stop_on_error("Stimulus file holds no test block");
        $display("PASS: all tests");
        $finish;
    end

endmodule : byte_cpu_tb

`default_nettype wire

// File: byte_cpu.f
+incdir+src
src/byte_cpu_pkg.sv
src/stage_link.sv
src/register_file.sv
src/alu.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/byte_cpu.sv
verification/clock_gen.sv
verification/byte_cpu_tb.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := byte_cpu_tb
FILELIST  := byte_cpu.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/byte_cpu_stimulus.txt
# Kind P is address and instruction word, R an input byte, E an expected output byte
# T runs the block above it, all values in hex
# Block 0 covers LDI, each ALU operation and a dependent chain through the bypass
P 00 005A  # ldi r0 5a
P 01 04C3  # ldi r1 c3
P 02 1801  # r2 = r0 + r1
P 03 7200  # out r2
P 04 1811  # r2 = r0 - r1
P 05 7200
P 06 1821  # r2 = r0 & r1
P 07 7200
P 08 1831  # r2 = r0 | r1
P 09 7200
P 0A 1841  # r2 = r0 ^ r1
P 0B 7200
P 0C 1851  # r2 = pass r1
P 0D 7200
P 0E 1D01  # r3 = r1 + r1
P 0F 1F03  # r3 = r3 + r3
P 10 1F40  # r3 = r3 ^ r0
P 11 7300  # out r3
P 12 9000  # halt
E 1D
E 97
E 42
E DB
E 99
E C3
E 56
T
# Block 1 covers a counted loop with JZ and JMP, then JC not taken and taken
P 00 0003  # ldi r0 03
P 01 0401  # ldi r1 01
P 02 08BD  # ldi r2 bd
P 03 7000  # out r0
P 04 1011  # r0 = r0 - r1
P 05 5008  # jz 08
P 06 4003  # jmp 03
P 07 7200  # flushed behind the jumps
P 08 1D11  # r3 = r1 - r1, zero without borrow
P 09 600C  # jc 0c, not taken
P 0A 7100  # out r1
P 0B 1E02  # r3 = r2 + r2, carry set
P 0C 600F  # jc 0f, taken
P 0D 7200  # flushed
P 0E 7200  # flushed
P 0F 7300  # out r3
P 10 9000  # halt
E 03
E 02
E 01
E 01
E 7A
T
# Block 2 covers ST then LD at several addresses
P 00 0011  # ldi r0 11
P 01 04EE  # ldi r1 ee
P 02 1841  # r2 = r0 ^ r1
P 03 3000  # st r0 [00]
P 04 31FF  # st r1 [ff]
P 05 3280  # st r2 [80]
P 06 2C80  # ld r3 [80]
P 07 7300
P 08 2CFF  # ld r3 [ff]
P 09 7300
P 0A 2C00  # ld r3 [00]
P 0B 7300
P 0C 9000  # halt
E FF
E EE
E 11
T
# Block 3 echoes six bytes through IN and OUT under random back-pressure
P 00 0C06  # ldi r3 06
P 01 0801  # ldi r2 01
P 02 8000  # in r0
P 03 7000  # out r0
P 04 1F12  # r3 = r3 - r2
P 05 5007  # jz 07
P 06 4002  # jmp 02
P 07 9000  # halt, flushed while the loop runs
R 00
R FF
R 5A
R A5
R 3C
R 81
E 00
E FF
E 5A
E A5
E 3C
E 81
T
